// File: design/trig_settings.svh
////////////////////
// Build settings for the debug trigger unit
// TRIG_NUM must be 1 to 4, a zero count is not supported
// Cause mask and tinfo must agree with the types the RTL decodes
////////////////////

`ifndef TRIG_SETTINGS_SVH
`define TRIG_SETTINGS_SVH

// Number of implemented triggers
`define TRIG_NUM 2

// Disabled trigger (type 15) with dmode set
`define TDATA1_RST_VAL 32'hF800_0000

// Implemented exception codes 0, 1, 2, 3, 5, 7, 8 and 11
`define ETRIG_CAUSE_MASK 32'h0000_09AF

// Version 1 in bits 31:24, types 5, 6 and 15 flagged in the low half
`define TINFO_VAL 32'h0100_8060

`endif

// File: design/trig_csr_pkg.sv
////////////////////
// Trigger register types and tdata1 field positions
// Field layout follows mcontrol6 (type 6) and etrigger (type 5)
// Widths of the per-trigger types come from TRIG_NUM
////////////////////

`default_nettype none

`include "trig_settings.svh"

package trig_csr_pkg;

  typedef logic [31:0]           tdata_t;      // One trigger CSR word
  typedef logic [`TRIG_NUM-1:0]  trig_vec_t;   // One bit per trigger
  typedef tdata_t [`TRIG_NUM-1:0] tdata_arr_t; // All tdata1 or all tdata2

  // tdata1.type encodings that the unit accepts
  typedef enum logic [3:0] {
    ETRIGGER  = 4'd5,
    MCONTROL6 = 4'd6,
    DISABLED  = 4'd15
  } ttype_e;

  // mcontrol6.match encodings that the unit accepts
  typedef enum logic [3:0] {
    EQ = 4'd0,
    GE = 4'd2,
    LT = 4'd3
  } match_rule_e;

  // CSR write bundle, one strobe per register
  typedef struct packed {
    tdata_t wdata;      // Write data shared by all strobes
    logic   tselect_we;
    logic   tdata1_we;
    logic   tdata2_we;
  } csr_wr_t;

  ////////////////////
  // tdata1 field positions
  ////////////////////
  localparam int TYPE_HI      = 31;
  localparam int TYPE_LO      = 28;
  localparam int DMODE        = 27; // Debug-mode-only access
  localparam int MC6_ACTION   = 12; // Low bit of action, 15:12
  localparam int MC6_MATCH_HI = 10;
  localparam int MC6_MATCH_LO = 7;
  localparam int MC6_M        = 6;
  localparam int MC6_U        = 3;
  localparam int MC6_EXECUTE  = 2;
  localparam int MC6_STORE    = 1;
  localparam int MC6_LOAD     = 0;
  localparam int ET_M         = 9;
  localparam int ET_U         = 6;
  localparam int ET_ACTION    = 0;  // Low bit of action, 5:0

endpackage

`default_nettype wire

// File: design/trig_pipe_pkg.sv
////////////////////
// Pipeline observation bundles seen by the trigger matchers
// Only M and U privilege exist, no S mode
////////////////////

`default_nettype none

package trig_pipe_pkg;

  typedef logic [31:0] addr_t;  // Fetch PC or data address
  typedef logic [3:0]  be_t;    // LSU byte enables
  typedef logic [10:0] cause_t; // Exception cause from writeback

  typedef enum logic [1:0] {
    U = 2'd0,
    M = 2'd3
  } priv_lvl_e;

  // Fetch stage
  typedef struct packed {
    addr_t     pc;
    logic      ptr;   // Fetch is a table pointer, never matched
    priv_lvl_e priv;
  } if_obs_t;

  // Execute stage LSU access
  typedef struct packed {
    logic      valid;
    addr_t     addr;
    logic      we;    // 1 for store
    be_t       be;
    priv_lvl_e priv;
  } lsu_obs_t;

  // Writeback stage exception
  typedef struct packed {
    logic      exc_valid;
    cause_t    cause;
    priv_lvl_e priv;
  } wb_obs_t;

  // Privilege gate shared by all matchers
  function automatic logic priv_hit(logic m_en, logic u_en, priv_lvl_e priv);
    return (m_en && (priv == M)) || (u_en && (priv == U));
  endfunction

endpackage

`default_nettype wire

// File: design/trig_csr_file.sv
////////////////////
// Trigger select and data registers
// tdata1/tdata2 writes target the trigger selected before this cycle
// Illegal tdata1 values resolve to a disabled trigger
// Read words follow tselect combinationally
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trig_settings.svh"

module trig_csr_file (
  input  logic                     clk,
  input  logic                     rst_i,
  input  trig_csr_pkg::csr_wr_t    csr_wr_i,
  output trig_csr_pkg::tdata_t     tselect_rdata_o,
  output trig_csr_pkg::tdata_t     tdata1_rdata_o,
  output trig_csr_pkg::tdata_t     tdata2_rdata_o,
  output trig_csr_pkg::tdata_t     tinfo_rdata_o,
  output trig_csr_pkg::tdata_arr_t tdata1_all_o,
  output trig_csr_pkg::tdata_arr_t tdata2_all_o
);
  import trig_csr_pkg::*;

  tdata_t     tselect_q;
  tdata_arr_t tdata1_q;
  tdata_arr_t tdata2_q;
  tdata_t     tdata1_n;  // Resolved tdata1 write value
  tdata_t     tdata2_n;  // Resolved tdata2 write value
  ttype_e     cur_type;  // Type of the selected trigger

  // Only EQ, GE and LT are kept, anything else falls back to EQ
  function automatic match_rule_e resolve_match(logic [3:0] rule);
    case (rule)
      4'd2:    return GE;
      4'd3:    return LT;
      default: return EQ;
    endcase
  endfunction

  ////////////////////
  // Write value resolution
  ////////////////////
  always_comb begin
    tdata1_n = `TDATA1_RST_VAL; // Default is a disabled trigger
    case (ttype_e'(csr_wr_i.wdata[TYPE_HI:TYPE_LO]))
      MCONTROL6: begin
        tdata1_n                           = '0;
        tdata1_n[TYPE_HI:TYPE_LO]          = MCONTROL6;
        tdata1_n[DMODE]                    = 1'b1;
        tdata1_n[MC6_ACTION]               = 1'b1;  // Enter debug on match
        tdata1_n[MC6_MATCH_HI:MC6_MATCH_LO] =
          resolve_match(csr_wr_i.wdata[MC6_MATCH_HI:MC6_MATCH_LO]);
        tdata1_n[MC6_M]       = csr_wr_i.wdata[MC6_M];
        tdata1_n[MC6_U]       = csr_wr_i.wdata[MC6_U];
        tdata1_n[MC6_EXECUTE] = csr_wr_i.wdata[MC6_EXECUTE];
        tdata1_n[MC6_STORE]   = csr_wr_i.wdata[MC6_STORE];
        tdata1_n[MC6_LOAD]    = csr_wr_i.wdata[MC6_LOAD];
      end
      ETRIGGER: begin
        // Legal only if tdata2 holds implemented causes alone
        if (!(|(tdata2_rdata_o & ~`ETRIG_CAUSE_MASK))) begin
          tdata1_n                  = '0;
          tdata1_n[TYPE_HI:TYPE_LO] = ETRIGGER;
          tdata1_n[DMODE]           = 1'b1;
          tdata1_n[ET_ACTION]       = 1'b1;
          tdata1_n[ET_M]            = csr_wr_i.wdata[ET_M];
          tdata1_n[ET_U]            = csr_wr_i.wdata[ET_U];
        end
      end
      default: tdata1_n = `TDATA1_RST_VAL; // Type 15 and every illegal type
    endcase
  end

  assign cur_type = ttype_e'(tdata1_rdata_o[TYPE_HI:TYPE_LO]);

  // Exception trigger keeps only implemented causes
  assign tdata2_n = (cur_type == ETRIGGER) ? (csr_wr_i.wdata & `ETRIG_CAUSE_MASK)
                                           : csr_wr_i.wdata;

  ////////////////////
  // Registers
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      tselect_q <= '0;
      for (int i = 0; i < `TRIG_NUM; i++) begin
        tdata1_q[i] <= `TDATA1_RST_VAL;
        tdata2_q[i] <= '0;
      end
    end else begin
      if (csr_wr_i.tselect_we && (csr_wr_i.wdata < `TRIG_NUM)) begin
        tselect_q <= csr_wr_i.wdata; // Out of range writes are dropped
      end
      for (int i = 0; i < `TRIG_NUM; i++) begin
        if (csr_wr_i.tdata1_we && (tselect_q == tdata_t'(i))) tdata1_q[i] <= tdata1_n;
        if (csr_wr_i.tdata2_we && (tselect_q == tdata_t'(i))) tdata2_q[i] <= tdata2_n;
      end
    end
  end

  // Read mux, trigger 0 by default
  always_comb begin
    tdata1_rdata_o = tdata1_q[0];
    tdata2_rdata_o = tdata2_q[0];
    for (int i = 1; i < `TRIG_NUM; i++) begin
      if (tselect_q == tdata_t'(i)) begin
        tdata1_rdata_o = tdata1_q[i];
        tdata2_rdata_o = tdata2_q[i];
      end
    end
  end

  assign tselect_rdata_o = tselect_q;
  assign tinfo_rdata_o   = `TINFO_VAL; // Read only
  assign tdata1_all_o    = tdata1_q;
  assign tdata2_all_o    = tdata2_q;

endmodule

`default_nettype wire

// File: design/trig_fetch_match.sv
////////////////////
// Instruction address match on the fetch PC
// Compares are unsigned, pointer fetches never match
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trig_settings.svh"

module trig_fetch_match (
  input  trig_pipe_pkg::if_obs_t   if_obs_i,
  input  logic                     debug_mode_i,
  input  trig_csr_pkg::tdata_arr_t tdata1_all_i,
  input  trig_csr_pkg::tdata_arr_t tdata2_all_i,
  output trig_csr_pkg::trig_vec_t  match_o
);
  import trig_csr_pkg::*;
  import trig_pipe_pkg::*;

  for (genvar t = 0; t < `TRIG_NUM; t++) begin : g_trig
    tdata_t t1;
    tdata_t t2;
    logic   addr_hit;

    assign t1 = tdata1_all_i[t];
    assign t2 = tdata2_all_i[t];

    // Compare by stored rule
    always_comb begin
      case (match_rule_e'(t1[MC6_MATCH_HI:MC6_MATCH_LO]))
        EQ:      addr_hit = (if_obs_i.pc == t2);
        GE:      addr_hit = (if_obs_i.pc >= t2);
        default: addr_hit = (if_obs_i.pc < t2);
      endcase
    end

    assign match_o[t] = (t1[TYPE_HI:TYPE_LO] == MCONTROL6) && t1[MC6_EXECUTE] &&
                        priv_hit(t1[MC6_M], t1[MC6_U], if_obs_i.priv) &&
                        !if_obs_i.ptr && !debug_mode_i && addr_hit;
  end

endmodule

`default_nettype wire

// File: design/trig_lsu_match.sv
////////////////////
// Load/store address match in execute
// Byte enables give the accessed range within the word
// Split misaligned accesses are checked one part at a time
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trig_settings.svh"

module trig_lsu_match (
  input  trig_pipe_pkg::lsu_obs_t  lsu_obs_i,
  input  logic                     debug_mode_i,
  input  trig_csr_pkg::tdata_arr_t tdata1_all_i,
  input  trig_csr_pkg::tdata_arr_t tdata2_all_i,
  output trig_csr_pkg::trig_vec_t  match_o
);
  import trig_csr_pkg::*;
  import trig_pipe_pkg::*;

  logic [1:0] lo_lsb;  // Lowest enabled byte lane
  logic [1:0] hi_lsb;  // Highest enabled byte lane
  addr_t      addr_lo;
  addr_t      addr_hi;

  always_comb begin
    lo_lsb = 2'd0;
    hi_lsb = 2'd0;
    for (int b = 0; b < 4; b++) begin
      if (lsu_obs_i.be[b]) hi_lsb = 2'(b);         // Last set lane wins
    end
    for (int b = 3; b >= 0; b--) begin
      if (lsu_obs_i.be[b]) lo_lsb = 2'(b);         // First set lane wins
    end
  end

  assign addr_lo = {lsu_obs_i.addr[31:2], lo_lsb};
  assign addr_hi = {lsu_obs_i.addr[31:2], hi_lsb};

  for (genvar t = 0; t < `TRIG_NUM; t++) begin : g_trig
    tdata_t t1;
    tdata_t t2;
    logic   addr_hit;
    logic   kind_hit; // Load or store enabled for this access

    assign t1 = tdata1_all_i[t];
    assign t2 = tdata2_all_i[t];

    always_comb begin
      case (match_rule_e'(t1[MC6_MATCH_HI:MC6_MATCH_LO]))
        EQ:      addr_hit = (lsu_obs_i.addr[31:2] == t2[31:2]) && lsu_obs_i.be[t2[1:0]];
        GE:      addr_hit = (addr_hi >= t2);  // Some byte is at or above tdata2
        default: addr_hit = (addr_lo < t2);   // Some byte is below tdata2
      endcase
    end

    assign kind_hit = lsu_obs_i.we ? t1[MC6_STORE] : t1[MC6_LOAD];

    assign match_o[t] = lsu_obs_i.valid && kind_hit &&
                        (t1[TYPE_HI:TYPE_LO] == MCONTROL6) &&
                        priv_hit(t1[MC6_M], t1[MC6_U], lsu_obs_i.priv) &&
                        !debug_mode_i && addr_hit;
  end

endmodule

`default_nettype wire

// File: design/trig_exc_match.sv
////////////////////
// Exception trigger in writeback
// Causes 32 and above never match
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trig_settings.svh"

module trig_exc_match (
  input  trig_pipe_pkg::wb_obs_t   wb_obs_i,
  input  logic                     debug_mode_i,
  input  trig_csr_pkg::tdata_arr_t tdata1_all_i,
  input  trig_csr_pkg::tdata_arr_t tdata2_all_i,
  output logic                     etrig_o
);
  import trig_csr_pkg::*;
  import trig_pipe_pkg::*;

  trig_vec_t hit;    // Per-trigger exception hit
  logic      cause_ok;

  // Cause fits the 32-bit tdata2 bit map
  assign cause_ok = wb_obs_i.exc_valid && (wb_obs_i.cause < 11'd32);

  for (genvar t = 0; t < `TRIG_NUM; t++) begin : g_trig
    tdata_t t1;
    tdata_t t2;

    assign t1 = tdata1_all_i[t];
    assign t2 = tdata2_all_i[t];

    assign hit[t] = (t1[TYPE_HI:TYPE_LO] == ETRIGGER) &&
                    priv_hit(t1[ET_M], t1[ET_U], wb_obs_i.priv) &&
                    cause_ok && t2[wb_obs_i.cause[4:0]] && !debug_mode_i;
  end

  assign etrig_o = |hit; // OR over all triggers

endmodule

`default_nettype wire

// File: design/debug_trigger_top.sv
////////////////////
// Debug trigger unit top level
// CSR writes are single-cycle strobes, visible one cycle later
// All match outputs are combinational levels
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trig_settings.svh"

module debug_trigger_top (
  input  logic                     clk,
  input  logic                     rst_i,
  input  trig_csr_pkg::csr_wr_t    csr_wr_i,
  input  trig_pipe_pkg::if_obs_t   if_obs_i,
  input  trig_pipe_pkg::lsu_obs_t  lsu_obs_i,
  input  trig_pipe_pkg::wb_obs_t   wb_obs_i,
  input  logic                     debug_mode_i,
  output trig_csr_pkg::tdata_t     tselect_rdata_o,
  output trig_csr_pkg::tdata_t     tdata1_rdata_o,
  output trig_csr_pkg::tdata_t     tdata2_rdata_o,
  output trig_csr_pkg::tdata_t     tinfo_rdata_o,
  output trig_csr_pkg::trig_vec_t  match_if_o,   // Fetch PC match per trigger
  output trig_csr_pkg::trig_vec_t  match_ex_o,   // Load/store match per trigger
  output logic                     etrig_wb_o    // Any exception trigger
);
  import trig_csr_pkg::*;

  tdata_arr_t tdata1_all; // Register state to matchers
  tdata_arr_t tdata2_all;

  // Register file
  trig_csr_file u_csr_file (
    .clk             (clk),
    .rst_i           (rst_i),
    .csr_wr_i        (csr_wr_i),
    .tselect_rdata_o (tselect_rdata_o),
    .tdata1_rdata_o  (tdata1_rdata_o),
    .tdata2_rdata_o  (tdata2_rdata_o),
    .tinfo_rdata_o   (tinfo_rdata_o),
    .tdata1_all_o    (tdata1_all),
    .tdata2_all_o    (tdata2_all)
  );

  ////////////////////
  // Matchers
  ////////////////////
  trig_fetch_match u_fetch_match (
    .if_obs_i     (if_obs_i),
    .debug_mode_i (debug_mode_i),
    .tdata1_all_i (tdata1_all),
    .tdata2_all_i (tdata2_all),
    .match_o      (match_if_o)
  );

  trig_lsu_match u_lsu_match (
    .lsu_obs_i    (lsu_obs_i),
    .debug_mode_i (debug_mode_i),
    .tdata1_all_i (tdata1_all),
    .tdata2_all_i (tdata2_all),
    .match_o      (match_ex_o)
  );

  trig_exc_match u_exc_match (
    .wb_obs_i     (wb_obs_i),
    .debug_mode_i (debug_mode_i),
    .tdata1_all_i (tdata1_all),
    .tdata2_all_i (tdata2_all),
    .etrig_o      (etrig_wb_o)
  );

endmodule

`default_nettype wire

// File: tb/trig_top_assert.sv
////////////////////
// Concurrent checks bound into debug_trigger_top
// Sampled on the rising edge, inputs must be stable there
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trig_settings.svh"

module trig_top_assert (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    debug_mode_i,
  input  trig_csr_pkg::tdata_t    tselect_i,
  input  trig_csr_pkg::trig_vec_t match_if_i,
  input  trig_csr_pkg::trig_vec_t match_ex_i,
  input  logic                    etrig_i
);

  logic any_match; // Any match output of any stage

  assign any_match = (|match_if_i) || (|match_ex_i) || etrig_i;

  // Debug mode masks every matcher
  no_match_in_debug: assert property (@(posedge clk) disable iff (rst_i)
    debug_mode_i |-> !any_match)
    else $error("Match output high while in debug mode");

  tselect_in_range: assert property (@(posedge clk) disable iff (rst_i)
    tselect_i < `TRIG_NUM)
    else $error("tselect outside the implemented trigger range");

  // Reset leaves all triggers disabled
  quiet_after_reset: assert property (@(posedge clk) rst_i |=> !any_match)
    else $error("Match output high in the cycle after reset");

endmodule

`default_nettype wire

// File: tb/tb_checker.sv
////////////////////
// Reference model of the trigger registers and matchers
// Model updates on the rising edge and compares 1 ns before the next one
// Expects byte enables to be nonzero on LSU accesses
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trig_settings.svh"

module tb_checker (
  input  logic                    clk,
  input  logic                    rst_i,
  input  trig_csr_pkg::csr_wr_t   csr_wr_i,
  input  trig_pipe_pkg::if_obs_t  if_obs_i,
  input  trig_pipe_pkg::lsu_obs_t lsu_obs_i,
  input  trig_pipe_pkg::wb_obs_t  wb_obs_i,
  input  logic                    debug_mode_i,
  input  trig_csr_pkg::tdata_t    tselect_i,
  input  trig_csr_pkg::tdata_t    tdata1_i,
  input  trig_csr_pkg::tdata_t    tdata2_i,
  input  trig_csr_pkg::tdata_t    tinfo_i,
  input  trig_csr_pkg::trig_vec_t match_if_i,
  input  trig_csr_pkg::trig_vec_t match_ex_i,
  input  logic                    etrig_i,
  output int                      chk_cnt_o,   // Compare cycles done
  output int                      err_cnt_o
);
  import trig_csr_pkg::*;
  import trig_pipe_pkg::*;

  localparam int SETTLE_NS = 19; // Just before the next rising edge

  tdata_t sel_m;                  // Model tselect
  tdata_t t1_m [`TRIG_NUM];       // Model tdata1 per trigger
  tdata_t t2_m [`TRIG_NUM];       // Model tdata2 per trigger
  int     chk_cnt = 0;
  int     err_cnt = 0;

  assign chk_cnt_o = chk_cnt;
  assign err_cnt_o = err_cnt;

  ////////////////////
  // Register rules
  ////////////////////
  // Legal tdata1 value for a write against the trigger's current tdata2
  function automatic tdata_t legal_tdata1(tdata_t wdata, tdata_t cur_t2);
    tdata_t     res;
    logic [3:0] rule;
    res  = `TDATA1_RST_VAL;
    rule = wdata[10:7];
    if (wdata[31:28] == 4'd6) begin
      if (rule != 4'd2 && rule != 4'd3) rule = 4'd0;   // Unknown rule falls back to EQ
      // Type 6, dmode, action 1, then m u execute store load
      res = 32'h6800_1000 | (wdata & 32'h0000_004F) | {21'd0, rule, 7'd0};
    end else if (wdata[31:28] == 4'd5 && (cur_t2 & ~(`ETRIG_CAUSE_MASK)) == 32'd0) begin
      res = 32'h5800_0001 | (wdata & 32'h0000_0240);   // Keep m (9) and u (6)
    end
    return res;
  endfunction

  function automatic logic priv_enabled(logic m_bit, logic u_bit, priv_lvl_e lvl);
    return (lvl == M) ? m_bit : ((lvl == U) ? u_bit : 1'b0);
  endfunction

  // Version 1 in bits 31:24 and one flag bit per supported type 5, 6 and 15
  function automatic tdata_t exp_tinfo();
    return (32'd1 << 24) | (32'd1 << 5) | (32'd1 << 6) | (32'd1 << 15);
  endfunction

  task automatic reset_model();
    sel_m = '0;
    for (int t = 0; t < `TRIG_NUM; t++) begin
      t1_m[t] = `TDATA1_RST_VAL;
      t2_m[t] = '0;
    end
  endtask

  // Writes hit the trigger selected before this edge and use the old state
  task automatic update_model();
    tdata_t new_t1;
    tdata_t new_t2;
    for (int t = 0; t < `TRIG_NUM; t++) begin
      if (sel_m == tdata_t'(t)) begin
        new_t1 = legal_tdata1(csr_wr_i.wdata, t2_m[t]);
        new_t2 = (t1_m[t][31:28] == 4'd5) ? (csr_wr_i.wdata & `ETRIG_CAUSE_MASK)
                                          : csr_wr_i.wdata;
        if (csr_wr_i.tdata1_we) t1_m[t] = new_t1;
        if (csr_wr_i.tdata2_we) t2_m[t] = new_t2;
      end
    end
    if (csr_wr_i.tselect_we && csr_wr_i.wdata < `TRIG_NUM) sel_m = csr_wr_i.wdata;
  endtask

  ////////////////////
  // Expected matches
  ////////////////////
  function automatic trig_vec_t exp_fetch();
    trig_vec_t v;
    logic      hit;
    v = '0;
    for (int t = 0; t < `TRIG_NUM; t++) begin
      case (t1_m[t][10:7])
        4'd2:    hit = (if_obs_i.pc >= t2_m[t]);
        4'd3:    hit = (if_obs_i.pc < t2_m[t]);
        default: hit = (if_obs_i.pc == t2_m[t]);
      endcase
      v[t] = (t1_m[t][31:28] == 4'd6) && t1_m[t][2] &&
             priv_enabled(t1_m[t][6], t1_m[t][3], if_obs_i.priv) &&
             !if_obs_i.ptr && !debug_mode_i && hit;
    end
    return v;
  endfunction

  function automatic trig_vec_t exp_lsu();
    trig_vec_t  v;
    logic       hit;
    logic       kind;
    logic [1:0] lo;   // Lowest enabled lane
    logic [1:0] hi;   // Highest enabled lane
    v  = '0;
    lo = 2'd0;
    hi = 2'd0;
    for (int b = 3; b >= 0; b--) begin
      if (lsu_obs_i.be[b]) lo = 2'(b);
    end
    for (int b = 0; b < 4; b++) begin
      if (lsu_obs_i.be[b]) hi = 2'(b);
    end
    for (int t = 0; t < `TRIG_NUM; t++) begin
      case (t1_m[t][10:7])
        4'd2:    hit = ({lsu_obs_i.addr[31:2], hi} >= t2_m[t]);
        4'd3:    hit = ({lsu_obs_i.addr[31:2], lo} < t2_m[t]);
        default: hit = (lsu_obs_i.addr[31:2] == t2_m[t][31:2]) &&
                       lsu_obs_i.be[t2_m[t][1:0]];
      endcase
      kind = lsu_obs_i.we ? t1_m[t][1] : t1_m[t][0];   // Store or load enable
      v[t] = lsu_obs_i.valid && kind && (t1_m[t][31:28] == 4'd6) &&
             priv_enabled(t1_m[t][6], t1_m[t][3], lsu_obs_i.priv) &&
             !debug_mode_i && hit;
    end
    return v;
  endfunction

  function automatic logic exp_exc();
    logic any;
    any = 1'b0;
    for (int t = 0; t < `TRIG_NUM; t++) begin
      if ((t1_m[t][31:28] == 4'd5) && priv_enabled(t1_m[t][9], t1_m[t][6], wb_obs_i.priv) &&
          wb_obs_i.exc_valid && (wb_obs_i.cause < 11'd32) &&
          t2_m[t][wb_obs_i.cause[4:0]] && !debug_mode_i) begin
        any = 1'b1;
      end
    end
    return any;
  endfunction

  ////////////////////
  // Compare
  ////////////////////
  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %s got 0x%08h expected 0x%08h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic compare_outputs();
    tdata_t exp_t1;
    tdata_t exp_t2;
    exp_t1 = t1_m[0];
    exp_t2 = t2_m[0];
    for (int t = 0; t < `TRIG_NUM; t++) begin
      if (sel_m == tdata_t'(t)) begin
        exp_t1 = t1_m[t];
        exp_t2 = t2_m[t];
      end
    end
    check_val("tselect_rdata_o", tselect_i, sel_m);
    check_val("tdata1_rdata_o", tdata1_i, exp_t1);
    check_val("tdata2_rdata_o", tdata2_i, exp_t2);
    check_val("tinfo_rdata_o", tinfo_i, exp_tinfo());
    check_val("match_if_o", 32'(match_if_i), 32'(exp_fetch()));
    check_val("match_ex_o", 32'(match_ex_i), 32'(exp_lsu()));
    check_val("etrig_wb_o", 32'(etrig_i), 32'(exp_exc()));
  endtask

  always begin
    @(posedge clk);
    if (rst_i) reset_model();
    else update_model();
    #(SETTLE_NS);
    if (!rst_i) begin
      chk_cnt++;
      compare_outputs();
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
////////////////////
// Testbench top for the debug trigger unit
// Random stimulus on falling edges from the fixed seed 81
// Addresses stay in a small window so compares hit often
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trig_settings.svh"

module tb_top;
  import trig_csr_pkg::*;
  import trig_pipe_pkg::*;

  localparam int HALF_PERIOD = 10;            // 20 ns clock
  localparam int NUM_CYCLES  = 2000;
  localparam int RST_TIMEOUT = 20;            // Cycles
  localparam int END_TIMEOUT = NUM_CYCLES + 50;

  logic      clk;
  logic      rst;
  csr_wr_t   csr_wr;
  if_obs_t   if_obs;
  lsu_obs_t  lsu_obs;
  wb_obs_t   wb_obs;
  logic      debug_mode;
  tdata_t    tselect_rdata;
  tdata_t    tdata1_rdata;
  tdata_t    tdata2_rdata;
  tdata_t    tinfo_rdata;
  trig_vec_t match_if;
  trig_vec_t match_ex;
  logic      etrig_wb;
  int        chk_cnt;
  int        err_cnt;

  debug_trigger_top debug_trigger_top_i (
    .clk             (clk),
    .rst_i           (rst),
    .csr_wr_i        (csr_wr),
    .if_obs_i        (if_obs),
    .lsu_obs_i       (lsu_obs),
    .wb_obs_i        (wb_obs),
    .debug_mode_i    (debug_mode),
    .tselect_rdata_o (tselect_rdata),
    .tdata1_rdata_o  (tdata1_rdata),
    .tdata2_rdata_o  (tdata2_rdata),
    .tinfo_rdata_o   (tinfo_rdata),
    .match_if_o      (match_if),
    .match_ex_o      (match_ex),
    .etrig_wb_o      (etrig_wb)
  );

  tb_checker u_checker (
    .clk          (clk),
    .rst_i        (rst),
    .csr_wr_i     (csr_wr),
    .if_obs_i     (if_obs),
    .lsu_obs_i    (lsu_obs),
    .wb_obs_i     (wb_obs),
    .debug_mode_i (debug_mode),
    .tselect_i    (tselect_rdata),
    .tdata1_i     (tdata1_rdata),
    .tdata2_i     (tdata2_rdata),
    .tinfo_i      (tinfo_rdata),
    .match_if_i   (match_if),
    .match_ex_i   (match_ex),
    .etrig_i      (etrig_wb),
    .chk_cnt_o    (chk_cnt),
    .err_cnt_o    (err_cnt)
  );

  bind debug_trigger_top trig_top_assert u_top_assert (
    .clk          (clk),
    .rst_i        (rst_i),
    .debug_mode_i (debug_mode_i),
    .tselect_i    (tselect_rdata_o),
    .match_if_i   (match_if_o),
    .match_ex_i   (match_ex_o),
    .etrig_i      (etrig_wb_o)
  );

  ////////////////////
  // Random values
  ////////////////////
  function automatic tdata_t near_addr();
    return 32'h0000_1000 + 32'($urandom_range(0, 15));  // Same window as tdata2
  endfunction

  // Mostly types 5 and 6 with rules 0, 2 and 3
  function automatic tdata_t rand_tdata1();
    tdata_t      w;
    int unsigned pick;
    w    = $urandom;
    pick = $urandom_range(0, 9);
    if (pick < 4) w[31:28] = 4'd6;
    else if (pick < 7) w[31:28] = 4'd5;
    else if (pick < 8) w[31:28] = 4'd15;
    pick = $urandom_range(0, 7);
    if (pick < 6) w[10:7] = (pick < 2) ? 4'd0 : ((pick < 4) ? 4'd2 : 4'd3);
    return w;
  endfunction

  function automatic tdata_t rand_tdata2();
    int unsigned pick;
    pick = $urandom_range(0, 9);
    if (pick < 5) return near_addr();
    else if (pick < 8) return `ETRIG_CAUSE_MASK & $urandom;   // Implemented causes only
    else return $urandom & 32'h0000_FFFF;                     // Some unimplemented causes
  endfunction

  task automatic drive_random();
    csr_wr.tselect_we = ($urandom_range(0, 4) == 0);
    csr_wr.tdata1_we  = ($urandom_range(0, 3) == 0);
    csr_wr.tdata2_we  = ($urandom_range(0, 3) == 0);
    if (csr_wr.tdata1_we) csr_wr.wdata = rand_tdata1();
    else if (csr_wr.tdata2_we) csr_wr.wdata = rand_tdata2();
    else csr_wr.wdata = 32'($urandom_range(0, `TRIG_NUM + 1)); // Some out of range
    if_obs.pc       = ($urandom_range(0, 9) == 0) ? $urandom : near_addr();
    if_obs.ptr      = ($urandom_range(0, 9) == 0);
    if_obs.priv     = ($urandom_range(0, 1) == 0) ? M : U;
    lsu_obs.valid   = ($urandom_range(0, 4) != 0);
    lsu_obs.addr    = near_addr();
    lsu_obs.we      = ($urandom_range(0, 1) == 1);
    lsu_obs.be      = 4'($urandom_range(1, 15));               // Never empty
    lsu_obs.priv    = ($urandom_range(0, 1) == 0) ? M : U;
    wb_obs.exc_valid = ($urandom_range(0, 1) == 0);
    wb_obs.cause    = ($urandom_range(0, 9) < 8) ? 11'($urandom_range(0, 11))
                                                 : 11'($urandom_range(0, 2047));
    wb_obs.priv     = ($urandom_range(0, 1) == 0) ? M : U;
    debug_mode      = ($urandom_range(0, 9) == 0);
  endtask

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Reset, then one random set of inputs per falling edge
  initial begin
    void'($urandom(81));
    rst        = 1'b1;
    csr_wr     = '0;
    if_obs     = '0;
    lsu_obs    = '0;
    wb_obs     = '0;
    debug_mode = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NUM_CYCLES; i++) begin
      drive_random();
      @(negedge clk);
    end
  end

  ////////////////////
  // Verdict
  ////////////////////
  initial begin
    int   waited;
    logic timed_out;
    waited    = 0;
    timed_out = 1'b0;
    while (rst !== 1'b0 && waited < RST_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (rst !== 1'b0) begin
      timed_out = 1'b1;
      $display("Timeout: reset was not released");
    end
    waited = 0;
    while (!timed_out && chk_cnt < NUM_CYCLES && waited < END_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!timed_out && chk_cnt < NUM_CYCLES) begin
      timed_out = 1'b1;
      $display("Timeout: checker did not finish its compare cycles");
    end
    $display("Checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, int'(timed_out));
    if (timed_out || err_cnt != 0) begin
      $display("SIMULATION FAILED");
    end else begin
      $display("SIMULATION PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/trig_csr_pkg.sv
design/trig_pipe_pkg.sv
design/trig_csr_file.sv
design/trig_fetch_match.sv
design/trig_lsu_match.sv
design/trig_exc_match.sv
design/debug_trigger_top.sv
tb/trig_top_assert.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: Makefile
# Verilator build and run for the debug trigger unit testbench

TOP := tb_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module $(TOP) -f project.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
